// ==== riscv_config.svh ====
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Word and register file geometry
`define XLEN       32
`define REG_COUNT  32
`define REG_ADDR_W 5

`define RESET_PC   32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR  32'h0000_0013

`define DMEM_WORDS 16

`endif

// ==== riscv_pkg.sv ====
`include "riscv_config.svh"

package riscv_pkg;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_valid;
        alu_op_e                alu_op;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   branch_ne;
        logic                   uses_imm;
    } decoded_t;

    typedef struct packed {
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_valid;
        logic                   is_load;
        logic                   is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]       value;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_valid;
        logic                   is_load;
    } mem_wb_t;

    typedef struct packed {
        logic             rd_en;
        logic             wr_en;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wr_data;
    } dmem_req_t;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               cache_stall,
    input  logic               load_use_stall,
    input  logic               branch_taken,
    input  logic [`XLEN-1:0]   branch_target,
    input  logic [`XLEN-1:0]   instr,
    output logic [`XLEN-1:0]   pc,
    output riscv_pkg::fetch_t  fetch
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= `RESET_PC;
            fetch.pc    <= `RESET_PC;
            fetch.instr <= `NOP_INSTR;
        end else if (!cache_stall) begin
            if (branch_taken) begin
                // Redirect, the word fetched this cycle is on the wrong path
                pc          <= branch_target;
                fetch.pc    <= pc;
                fetch.instr <= `NOP_INSTR;
            end else if (!load_use_stall) begin
                pc          <= pc + `XLEN'd4;
                fetch.pc    <= pc;
                fetch.instr <= instr;
            end
        end
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cache_stall,
    input  logic                   load_use_stall,
    input  logic                   branch_taken,
    input  riscv_pkg::fetch_t      fetch,
    input  logic [`XLEN-1:0]       rs1_value,
    input  logic [`XLEN-1:0]       rs2_value,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic                   rs1_used,
    output logic                   rs2_used,
    output riscv_pkg::decoded_t    decoded
);

    logic [`XLEN-1:0]    instr;
    logic [2:0]          funct3;
    logic                legal;
    riscv_pkg::alu_op_e  logic_op;
    riscv_pkg::decoded_t ctrl;

    assign instr  = fetch.instr;
    assign funct3 = instr[14:12];

    // add, xor, or, and share their funct3 between OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b100:  logic_op = riscv_pkg::ALU_XOR;
            3'b110:  logic_op = riscv_pkg::ALU_OR;
            3'b111:  logic_op = riscv_pkg::ALU_AND;
            default: logic_op = riscv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        ctrl.pc  = fetch.pc;
        ctrl.rd  = instr[11:7];
        legal    = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (riscv_pkg::opcode_e'(instr[6:0]))
            riscv_pkg::OP: begin
                legal = (funct3 == 3'b000 || (funct3[2] && funct3[1:0] != 2'b01))
                    && instr[31] == 1'b0 && instr[29:25] == 5'd0
                    && (!instr[30] || funct3 == 3'b000);
                rs1_used      = 1'b1;
                rs2_used      = 1'b1;
                ctrl.rd_valid = 1'b1;
                ctrl.alu_op   = instr[30] ? riscv_pkg::ALU_SUB : logic_op;
            end
            riscv_pkg::OP_IMM: begin
                legal = funct3 == 3'b000 || (funct3[2] && funct3[1:0] != 2'b01);
                rs1_used      = 1'b1;
                ctrl.rd_valid = 1'b1;
                ctrl.uses_imm = 1'b1;
                ctrl.alu_op   = logic_op;
                ctrl.imm      = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            riscv_pkg::LOAD: begin
                legal         = funct3 == 3'b010;
                rs1_used      = 1'b1;
                ctrl.rd_valid = 1'b1;
                ctrl.is_load  = 1'b1;
                ctrl.uses_imm = 1'b1;
                ctrl.imm      = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            riscv_pkg::STORE: begin
                legal         = funct3 == 3'b010;
                rs1_used      = 1'b1;
                rs2_used      = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.uses_imm = 1'b1;
                ctrl.imm      = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            riscv_pkg::BRANCH: begin
                legal          = funct3[2:1] == 2'b00;
                rs1_used       = 1'b1;
                rs2_used       = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                ctrl.imm       = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            end
            default: legal = 1'b0;
        endcase
        // Unsupported encodings run as a NOP
        if (!legal) begin
            ctrl     = '0;
            ctrl.pc  = fetch.pc;
            rs1_used = 1'b0;
            rs2_used = 1'b0;
        end
        ctrl.rs1 = rs1_used ? instr[19:15] : '0;
        ctrl.rs2 = rs2_used ? instr[24:20] : '0;
    end

    assign rs1 = ctrl.rs1;
    assign rs2 = ctrl.rs2;

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (!cache_stall) begin
            if (branch_taken || load_use_stall) begin
                decoded <= '0;
            end else begin
                decoded           <= ctrl;
                decoded.rs1_value <= rs1_value;
                decoded.rs2_value <= rs2_value;
            end
        end
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module register_file (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    input  riscv_pkg::mem_wb_t     wb
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_en;

    assign wr_en = wb.rd_valid && wb.rd != '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rs1_value = (rs1 == '0) ? '0 : (wr_en && wb.rd == rs1) ? wb.value : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : (wr_en && wb.rd == rs2) ? wb.value : regs[rs2];

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module hazard_unit (
    input  logic                   [`REG_ADDR_W-1:0] rs1,
    input  logic                   [`REG_ADDR_W-1:0] rs2,
    input  logic                   rs1_used,
    input  logic                   rs2_used,
    input  riscv_pkg::decoded_t    decoded,
    input  riscv_pkg::ex_mem_t     ex_mem,
    input  riscv_pkg::mem_wb_t     mem_wb,
    output logic                   load_use_stall,
    output riscv_pkg::fwd_sel_e    fwd_a,
    output riscv_pkg::fwd_sel_e    fwd_b
);

    logic load_in_ex;

    // Newest producer wins
    function automatic riscv_pkg::fwd_sel_e select(
        input logic [`REG_ADDR_W-1:0] src,
        input riscv_pkg::ex_mem_t     mem,
        input riscv_pkg::mem_wb_t     wb
    );
        if (src != '0 && mem.rd_valid && mem.rd == src) begin
            return riscv_pkg::FWD_MEM;
        end else if (src != '0 && wb.rd_valid && wb.rd == src) begin
            return riscv_pkg::FWD_WB;
        end
        return riscv_pkg::FWD_NONE;
    endfunction

    assign fwd_a = select(decoded.rs1, ex_mem, mem_wb);
    assign fwd_b = select(decoded.rs2, ex_mem, mem_wb);

    assign load_in_ex     = decoded.is_load && decoded.rd_valid && decoded.rd != '0;
    assign load_use_stall = load_in_ex && ((rs1_used && rs1 == decoded.rd)
                                        || (rs2_used && rs2 == decoded.rd));

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                cache_stall,
    input  riscv_pkg::decoded_t decoded,
    input  riscv_pkg::fwd_sel_e fwd_a,
    input  riscv_pkg::fwd_sel_e fwd_b,
    input  logic [`XLEN-1:0]    wb_value,
    output riscv_pkg::ex_mem_t  ex_mem,
    output logic                branch_taken,
    output logic [`XLEN-1:0]    branch_target
);

    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   rs2_fwd;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   result;
    riscv_pkg::ex_mem_t next;

    function automatic logic [`XLEN-1:0] pick(
        input riscv_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0]    reg_value,
        input logic [`XLEN-1:0]    mem_value,
        input logic [`XLEN-1:0]    wb_val
    );
        case (sel)
            riscv_pkg::FWD_MEM: return mem_value;
            riscv_pkg::FWD_WB:  return wb_val;
            default:            return reg_value;
        endcase
    endfunction

    assign op_a    = pick(fwd_a, decoded.rs1_value, ex_mem.result, wb_value);
    assign rs2_fwd = pick(fwd_b, decoded.rs2_value, ex_mem.result, wb_value);
    assign op_b    = decoded.uses_imm ? decoded.imm : rs2_fwd;

    // Also forms the load/store address
    always_comb begin
        case (decoded.alu_op)
            riscv_pkg::ALU_SUB: result = op_a - op_b;
            riscv_pkg::ALU_AND: result = op_a & op_b;
            riscv_pkg::ALU_OR:  result = op_a | op_b;
            riscv_pkg::ALU_XOR: result = op_a ^ op_b;
            default:            result = op_a + op_b;
        endcase
    end

    assign branch_taken  = decoded.is_branch && ((op_a == rs2_fwd) != decoded.branch_ne);
    assign branch_target = decoded.pc + decoded.imm;

    always_comb begin
        next.result     = result;
        next.store_data = rs2_fwd;
        next.rd         = decoded.rd;
        next.rd_valid   = decoded.rd_valid;
        next.is_load    = decoded.is_load;
        next.is_store   = decoded.is_store;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (!cache_stall) begin
            ex_mem <= next;
        end
    end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module memory_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cache_stall,
    input  riscv_pkg::ex_mem_t   ex_mem,
    input  logic [`XLEN-1:0]     read_data,
    output riscv_pkg::dmem_req_t dmem_req,
    output riscv_pkg::mem_wb_t   mem_wb
);

    // Request is combinational, read data comes back in the same cycle
    always_comb begin
        dmem_req.rd_en   = ex_mem.is_load;
        dmem_req.wr_en   = ex_mem.is_store;
        dmem_req.addr    = ex_mem.result;
        dmem_req.wr_data = ex_mem.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
        end else if (!cache_stall) begin
            mem_wb.value    <= ex_mem.is_load ? read_data : ex_mem.result;
            mem_wb.rd       <= ex_mem.rd;
            mem_wb.rd_valid <= ex_mem.rd_valid;
            mem_wb.is_load  <= ex_mem.is_load;
        end
    end

endmodule

// ==== riscv_cpu.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module riscv_cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`XLEN-1:0]     instr,
    output logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     read_data,
    output riscv_pkg::dmem_req_t dmem_req,
    input  logic                 cache_stall
);

    riscv_pkg::fetch_t      fetch;
    riscv_pkg::decoded_t    decoded;
    riscv_pkg::ex_mem_t     ex_mem;
    riscv_pkg::mem_wb_t     mem_wb;
    riscv_pkg::fwd_sel_e    fwd_a;
    riscv_pkg::fwd_sel_e    fwd_b;
    logic                   load_use_stall;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic                   rs1_used;
    logic                   rs2_used;
    logic [`XLEN-1:0]       rs1_value;
    logic [`XLEN-1:0]       rs2_value;

    fetch_stage fetch_stage_inst (
        .clk(clk), .reset(reset), .cache_stall(cache_stall),
        .load_use_stall(load_use_stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .instr(instr), .pc(pc), .fetch(fetch)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .reset(reset), .cache_stall(cache_stall),
        .load_use_stall(load_use_stall), .branch_taken(branch_taken), .fetch(fetch),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .rs1(rs1), .rs2(rs2),
        .rs1_used(rs1_used), .rs2_used(rs2_used), .decoded(decoded)
    );

    register_file register_file_inst (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rs1_value(rs1_value),
        .rs2_value(rs2_value), .wb(mem_wb)
    );

    hazard_unit hazard_unit_inst (
        .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .decoded(decoded), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .load_use_stall(load_use_stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage execute_stage_inst (
        .clk(clk), .reset(reset), .cache_stall(cache_stall), .decoded(decoded),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_value(mem_wb.value), .ex_mem(ex_mem),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    memory_stage memory_stage_inst (
        .clk(clk), .reset(reset), .cache_stall(cache_stall), .ex_mem(ex_mem),
        .read_data(read_data), .dmem_req(dmem_req), .mem_wb(mem_wb)
    );

endmodule

// ==== riscv_cpu_checker.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module riscv_cpu_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 cache_stall,
    input logic [`XLEN-1:0]     pc,
    input riscv_pkg::dmem_req_t dmem_req
);

    logic mem_active;

    assign mem_active = dmem_req.rd_en || dmem_req.wr_en;

    one_request: assert property (@(posedge clk) disable iff (reset)
        !(dmem_req.rd_en && dmem_req.wr_en))
        else $error("Load and store requested in the same cycle");

    aligned_addr: assert property (@(posedge clk) disable iff (reset)
        mem_active |-> dmem_req.addr[1:0] == 2'b00)
        else $error("Data address %h is not word aligned", dmem_req.addr);

    // Random program only touches the small data memory
    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        mem_active |-> dmem_req.addr < 32'(`DMEM_WORDS * 4))
        else $error("Data address %h is outside the data memory", dmem_req.addr);

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        cache_stall |=> $stable(pc) && $stable(dmem_req))
        else $error("pc or data request changed during a cache stall");

    reset_pc: assert property (@(posedge clk) $fell(reset) |-> pc == `RESET_PC)
        else $error("pc is %h after reset", pc);

endmodule

// ==== riscv_cpu_tb.sv ====
`timescale 1ns/100ps
`include "riscv_config.svh"

module riscv_cpu_tb;

    localparam int SEED       = 49;
    localparam int RAND_LEN   = 48;
    localparam int LOOP_INDEX = RAND_LEN + 7;
    localparam int PROG_LEN   = LOOP_INDEX + 1;
    localparam int MAX_CYCLES = PROG_LEN * 20;
    localparam int MEM_IDX_W  = $clog2(`DMEM_WORDS);
    localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4, K_ADDI = 5,
                   K_ANDI = 6, K_ORI = 7, K_XORI = 8, K_LW = 9, K_SW = 10, K_BEQ = 11,
                   K_BNE = 12;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 cache_stall = 1'b0;
    logic [`XLEN-1:0]     instr;
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     read_data;
    riscv_pkg::dmem_req_t dmem_req;

    int               kind [PROG_LEN];
    logic [4:0]       rd_of [PROG_LEN];
    logic [4:0]       rs1_of [PROG_LEN];
    logic [4:0]       rs2_of [PROG_LEN];
    logic [`XLEN-1:0] imm_of [PROG_LEN];
    logic [`XLEN-1:0] imem [64];
    logic [`XLEN-1:0] init_mem [`DMEM_WORDS];
    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    logic [`XLEN-1:0] stall_rng = SEED;
    int               errors = 0;
    int               commits = 0;
    int               expected_stores = 0;
    int               cycles = 0;

    riscv_cpu riscv_cpu_inst (
        .clk(clk), .reset(reset), .instr(instr), .pc(pc), .read_data(read_data),
        .dmem_req(dmem_req), .cache_stall(cache_stall)
    );

    bind riscv_cpu riscv_cpu_checker riscv_cpu_checker_inst (
        .clk(clk), .reset(reset), .cache_stall(cache_stall), .pc(pc), .dmem_req(dmem_req)
    );

    always #5 clk = ~clk;

    assign instr     = (pc[`XLEN-1:8] == '0) ? imem[pc[7:2]] : `NOP_INSTR;
    // Read data is only valid for an enabled read
    assign read_data = dmem_req.rd_en ? dmem[dmem_req.addr[MEM_IDX_W+1:2]]
                                      : ~dmem[dmem_req.addr[MEM_IDX_W+1:2]];

    function automatic logic [`XLEN-1:0] xorshift(input logic [`XLEN-1:0] state);
        logic [`XLEN-1:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory stall roughly one cycle in four
    always @(posedge clk) begin
        #1;
        stall_rng = xorshift(stall_rng);
        cache_stall = stall_rng[1:0] == 2'b00;
    end

    function automatic logic [`XLEN-1:0] encode(input int k, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2,
                                                input logic [`XLEN-1:0] imm);
        case (k)
            K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            K_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            K_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            default: return `NOP_INSTR;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Seven register setups, random body, store dump of x1..x7, then a self-loop
    task automatic build_program(inout logic [`XLEN-1:0] rng);
        logic [4:0] prev_rd;
        int         target;
        prev_rd = 5'd1;
        foreach (imem[i]) imem[i] = `NOP_INSTR;
        for (int i = 0; i < PROG_LEN; i++) begin
            rng = xorshift(rng);
            kind[i]   = (i < 7) ? K_ADDI : int'(rng[7:0]) % 13;
            rd_of[i]  = (i < 7) ? 5'(i + 1) : 5'(1 + int'(rng[10:8]) % 7);
            rs1_of[i] = rng[11] ? prev_rd : 5'(1 + int'(rng[14:12]) % 7);
            rs2_of[i] = rng[15] ? prev_rd : 5'(1 + int'(rng[18:16]) % 7);
            imm_of[i] = {{20{rng[31]}}, rng[31:20]};
            if (i < 7) begin
                rs1_of[i] = '0;
            end
            if (kind[i] == K_LW || kind[i] == K_SW) begin
                rs1_of[i] = '0;
                imm_of[i] = 32'(int'(rng[23:20]) % `DMEM_WORDS) << 2;
            end
            if (kind[i] >= K_BEQ) begin
                target = i + 2 + int'(rng[21:20]) % 3;
                if (target > RAND_LEN) begin
                    target = RAND_LEN;
                end
                imm_of[i] = 32'((target - i) * 4);
            end
            if (i >= RAND_LEN && i < LOOP_INDEX) begin
                kind[i]   = K_SW;
                rs1_of[i] = '0;
                rs2_of[i] = 5'(i - RAND_LEN + 1);
                imm_of[i] = 32'((i - RAND_LEN) * 4);
            end
            if (i == LOOP_INDEX) begin
                kind[i]   = K_BEQ;
                rs1_of[i] = '0;
                rs2_of[i] = '0;
                imm_of[i] = '0;
            end
            if (kind[i] < K_SW) begin
                prev_rd = rd_of[i];
            end
            imem[i] = encode(kind[i], rd_of[i], rs1_of[i], rs2_of[i], imm_of[i]);
        end
    endtask

    // In-order reference run, records the stores the core has to commit
    task automatic run_model();
        logic [`XLEN-1:0] regs [32];
        logic [`XLEN-1:0] mem [`DMEM_WORDS];
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] rv2;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] result;
        int               idx;
        foreach (regs[r]) regs[r] = '0;
        mem = init_mem;
        idx = 0;
        while (idx != LOOP_INDEX) begin
            a    = regs[rs1_of[idx]];
            rv2  = regs[rs2_of[idx]];
            b    = (kind[idx] >= K_ADDI && kind[idx] <= K_LW) ? imm_of[idx] : rv2;
            addr = a + imm_of[idx];
            case (kind[idx])
                K_SUB:         result = a - b;
                K_AND, K_ANDI: result = a & b;
                K_OR, K_ORI:   result = a | b;
                K_XOR, K_XORI: result = a ^ b;
                K_LW:          result = mem[addr[MEM_IDX_W+1:2]];
                default:       result = a + b;
            endcase
            if (kind[idx] == K_SW) begin
                mem[addr[MEM_IDX_W+1:2]] = rv2;
                exp_addr.push_back(addr);
                exp_data.push_back(rv2);
            end else if (kind[idx] < K_SW) begin
                regs[rd_of[idx]] = result;
            end
            if ((kind[idx] == K_BEQ && a == rv2) || (kind[idx] == K_BNE && a != rv2)) begin
                idx = idx + int'(imm_of[idx] >> 2);
            end else begin
                idx++;
            end
        end
        expected_stores = exp_addr.size();
    endtask

    task automatic commit_store();
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
        if (exp_addr.size() == 0) begin
            $display("Store to %h committed but the model expects no more stores",
                     dmem_req.addr);
            errors++;
        end else begin
            addr = exp_addr.pop_front();
            data = exp_data.pop_front();
            check_value($sformatf("store %0d address", commits), addr, dmem_req.addr);
            check_value($sformatf("store %0d data", commits), data, dmem_req.wr_data);
        end
        dmem[dmem_req.addr[MEM_IDX_W+1:2]] = dmem_req.wr_data;
        commits++;
    endtask

    initial begin
        logic [`XLEN-1:0]     rng;
        logic                 prev_stall;
        logic [`XLEN-1:0]     prev_pc;
        riscv_pkg::dmem_req_t prev_req;
        logic                 done;
        int                   loop_visits;
        rng = SEED;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            rng = xorshift(rng);
            init_mem[i] = rng;
            dmem[i] = rng;
        end
        build_program(rng);
        run_model();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        check_value("pc after reset", `RESET_PC, pc);
        check_value("requests after reset", '0, 32'({dmem_req.rd_en, dmem_req.wr_en}));
        prev_stall  = cache_stall;
        prev_pc     = pc;
        prev_req    = dmem_req;
        loop_visits = 0;
        done        = 1'b0;
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            // No memory instruction can reach the port this early
            if (cycles <= 8) begin
                check_value("early requests", '0, 32'({dmem_req.rd_en, dmem_req.wr_en}));
            end
            if (prev_stall) begin
                check_value("pc held by stall", prev_pc, pc);
                check_value("address held by stall", prev_req.addr, dmem_req.addr);
                check_value("store data held by stall", prev_req.wr_data, dmem_req.wr_data);
                check_value("enables held by stall", 32'({prev_req.rd_en, prev_req.wr_en}),
                            32'({dmem_req.rd_en, dmem_req.wr_en}));
            end
            if (dmem_req.wr_en && !cache_stall) begin
                commit_store();
            end
            // Second arrival comes from the loop's own taken branch, all stores are out
            if (pc == 32'(LOOP_INDEX * 4) && prev_pc != pc) begin
                loop_visits++;
            end
            prev_stall = cache_stall;
            prev_pc    = pc;
            prev_req   = dmem_req;
            done       = loop_visits == 2;
        end
        if (!done) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles",
                     MAX_CYCLES);
            errors++;
        end
        check_value("committed store count", 32'(expected_stores), 32'(commits));
        $display("Errors: %0d, stores committed: %0d of %0d", errors, commits,
                 expected_stores);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
riscv_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
riscv_cpu.sv
riscv_cpu_checker.sv
riscv_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module riscv_cpu_tb \
    -o riscv_cpu_sim > build.log 2>&1 \
    && ./obj_dir/riscv_cpu_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
